// File: verilog/ice_cmd_pkg.sv
// ============================================================
// Command engine shared types
// ============================================================
package ice_cmd_pkg;

    // ============================================================
    // Host link framing
    // ============================================================
    localparam int msg_len      = 64;   // Bits after the start bit
    localparam int resp_len     = 64;   // Bits driven back to the host
    localparam int msg_type_len = 8;
    localparam int msg_arg_len  = msg_len - msg_type_len;

    // Top type bit asks for a response
    localparam int msg_type_resp_bit = 7;

    // Message types understood by the decoder
    typedef enum logic [msg_type_len-1:0] {
        msg_nop     = 8'h00,
        msg_led_set = 8'h02,
        msg_echo    = 8'h81,
        msg_status  = 8'h83
    } msg_type_e;

    // Incoming message, type in the upper byte
    typedef struct packed {
        logic [msg_type_len-1:0] msg_type;
        logic [msg_arg_len-1:0]  arg;
    } spi_msg_t;

    // Outgoing response word, MSB goes out first
    typedef logic [resp_len-1:0] spi_resp_t;

    // ============================================================
    // Board state
    // ============================================================
    typedef logic [3:0] led_t;

    // Layout of the Status answer
    typedef struct packed {
        logic [54:0] zero;          // Always zero
        logic        bad_cmd;       // Sticky, unknown type seen
        led_t        led;
        logic [3:0]  access_mode;   // From the last CMD6 block
    } status_resp_t;

    // ============================================================
    // SD data-in stream
    // ============================================================
    typedef logic [15:0] sd_word_t;

    // Word 8 of the CMD6 status block holds the access mode nibble
    localparam int cmd6_mode_word_idx = 8;
    localparam int cmd6_block_words   = 32;   // 512 bits in 16-bit words

endpackage

// File: verilog/spi_msg_rx.sv
`timescale 1ns/1ps

// Serial message receiver
// A high bit while idle marks the start, then 64 bits MSB first
module spi_msg_rx (
    input  logic                  sd_datInWrite_clk,
    input  logic                  sd_datInWrite_rst_,
    input  logic                  data_in,
    output ice_cmd_pkg::spi_msg_t msg,
    output logic                  msg_valid
);
    import ice_cmd_pkg::*;

    localparam int bit_cnt_w = $clog2(msg_len);

    typedef enum logic [0:0] {
        rx_idle,
        rx_shift
    } rx_state_e;

    rx_state_e              state_q;
    logic [bit_cnt_w-1:0]   bit_cnt_q;  // Bits still to come, minus one
    logic [msg_len-1:0]     shift_q;

    // ============================================================
    // Control
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state_q   <= rx_idle;
            bit_cnt_q <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            case (state_q)
                rx_idle: begin
                    // Start bit
                    if (data_in) begin
                        bit_cnt_q <= bit_cnt_w'(msg_len - 1);
                        state_q   <= rx_shift;
                    end
                end
                rx_shift: begin
                    if (bit_cnt_q == '0) begin
                        // Last bit goes in this edge
                        msg_valid <= 1'b1;
                        state_q   <= rx_idle;
                    end else begin
                        bit_cnt_q <= bit_cnt_q - bit_cnt_w'(1);
                    end
                end
                default: state_q <= rx_idle;
            endcase
        end
    end

    // ============================================================
    // Shift register
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state_q == rx_shift) begin
            shift_q <= {shift_q[msg_len-2:0], data_in};
        end
    end

    // Held stable while idle, so the next start bit does not disturb it
    assign msg = spi_msg_t'(shift_q);

endmodule

// File: verilog/cmd_exec.sv
`timescale 1ns/1ps

// Message decoder and executor
// Owns the LED register and the sticky bad command flag
module cmd_exec (
    input  logic                   sd_datInWrite_clk,
    input  logic                   sd_datInWrite_rst_,
    input  ice_cmd_pkg::spi_msg_t  msg,
    input  logic                   msg_valid,
    input  logic [3:0]             access_mode,
    output ice_cmd_pkg::led_t      led,
    output ice_cmd_pkg::spi_resp_t resp,
    output logic                   resp_load
);
    import ice_cmd_pkg::*;

    msg_type_e      msg_type;
    logic           resp_wanted;
    logic           bad_cmd_q;
    status_resp_t   status_w;

    assign msg_type    = msg_type_e'(msg.msg_type);
    assign resp_wanted = msg.msg_type[msg_type_resp_bit];

    // ============================================================
    // Status word
    // ============================================================
    // Values from before the current message
    always_comb begin
        status_w             = '0;
        status_w.bad_cmd     = bad_cmd_q;
        status_w.led         = led;
        status_w.access_mode = access_mode;
    end

    // ============================================================
    // Control state
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            led       <= '0;
            bad_cmd_q <= 1'b0;
            resp_load <= 1'b0;
        end else begin
            resp_load <= 1'b0;
            if (msg_valid) begin
                resp_load <= resp_wanted;   // Any type with bit 7 set answers
                case (msg_type)
                    msg_nop,
                    msg_echo,
                    msg_status: begin
                        // Nothing to change here
                    end
                    msg_led_set: begin
                        led <= msg.arg[3:0];
                    end
                    default: begin
                        bad_cmd_q <= 1'b1;
                    end
                endcase
            end
        end
    end

    // ============================================================
    // Response word
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (msg_valid) begin
            case (msg_type)
                msg_echo: begin
                    resp <= {{msg_type_len{1'b0}}, msg.arg};
                end
                msg_status: begin
                    resp <= spi_resp_t'(status_w);
                end
                msg_nop,
                msg_led_set: begin
                    resp <= resp;   // No answer, keep last word
                end
                default: begin
                    resp <= '0;     // Unknown type, zeros if answered
                end
            endcase
        end
    end

endmodule

// File: verilog/spi_resp_tx.sv
`timescale 1ns/1ps

// Serial response transmitter
// Waits out the turnaround, then drives 64 bits with data_oe high
module spi_resp_tx #(
    parameter int unsigned turnaround_cycles = 6
) (
    input  logic                   sd_datInWrite_clk,
    input  logic                   sd_datInWrite_rst_,
    input  ice_cmd_pkg::spi_resp_t resp,
    input  logic                   resp_load,
    output logic                   data_out,
    output logic                   data_oe
);
    import ice_cmd_pkg::*;

    // Counter covers both the turnaround and the response bits
    localparam int cnt_w = ($clog2(turnaround_cycles) > $clog2(resp_len)) ?
                           $clog2(turnaround_cycles) : $clog2(resp_len);

    typedef enum logic [1:0] {
        tx_idle,
        tx_turnaround,
        tx_send
    } tx_state_e;

    tx_state_e          state_q;
    logic [cnt_w-1:0]   cnt_q;
    spi_resp_t          shift_q;

    // ============================================================
    // Control
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state_q  <= tx_idle;
            cnt_q    <= '0;
            data_oe  <= 1'b0;
            data_out <= 1'b0;
        end else if (resp_load) begin
            // New response always wins, even mid transfer
            state_q <= tx_turnaround;
            cnt_q   <= cnt_w'(turnaround_cycles - 1);
            data_oe <= 1'b0;
        end else begin
            case (state_q)
                tx_idle: ;
                tx_turnaround: begin
                    if (cnt_q == '0) begin
                        data_oe  <= 1'b1;
                        data_out <= shift_q[resp_len-1];
                        cnt_q    <= cnt_w'(resp_len - 1);
                        state_q  <= tx_send;
                    end else begin
                        cnt_q <= cnt_q - cnt_w'(1);
                    end
                end
                tx_send: begin
                    if (cnt_q == '0) begin
                        data_oe <= 1'b0;    // All 64 bits out
                        state_q <= tx_idle;
                    end else begin
                        data_out <= shift_q[resp_len-1];
                        cnt_q    <= cnt_q - cnt_w'(1);
                    end
                end
                default: state_q <= tx_idle;
            endcase
        end
    end

    // ============================================================
    // Shift register
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (resp_load) begin
            shift_q <= resp;
        end else if (data_out_advance(state_q, cnt_q)) begin
            shift_q <= {shift_q[resp_len-2:0], 1'b0};
        end
    end

    // True on every edge that moves a bit to data_out
    function automatic logic data_out_advance(tx_state_e state, logic [cnt_w-1:0] cnt);
        logic adv;
        adv = 1'b0;
        if (state == tx_turnaround && cnt == '0) begin
            adv = 1'b1;
        end else if (state == tx_send && cnt != '0) begin
            adv = 1'b1;
        end
        return adv;
    endfunction

endmodule

// File: verilog/cmd6_mode_capture.sv
`timescale 1ns/1ps

// CMD6 access mode capture from the SD data-in word stream
module cmd6_mode_capture (
    input  logic                  sd_datInWrite_clk,
    input  logic                  sd_datInWrite_rst_,
    input  logic                  dat_block_start,
    input  logic                  dat_trigger,
    input  ice_cmd_pkg::sd_word_t dat_data,
    output logic [3:0]            access_mode
);
    import ice_cmd_pkg::*;

    localparam int cnt_w = $clog2(cmd6_block_words + 1);

    logic [cnt_w-1:0] word_cnt_q;   // Words seen in this block
    logic             mode_word;

    assign mode_word = dat_trigger && (word_cnt_q == cnt_w'(cmd6_mode_word_idx));

    // ============================================================
    // Word counter
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_cnt_q <= '0;
        end else if (dat_block_start) begin
            word_cnt_q <= '0;
        end else if (dat_trigger && word_cnt_q != cnt_w'(cmd6_block_words)) begin
            word_cnt_q <= word_cnt_q + cnt_w'(1);  // Stops at a full block
        end
    end

    // Access mode sits in bits 11..8 of the selected word
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            access_mode <= '0;
        end else if (mode_word) begin
            access_mode <= dat_data[11:8];
        end
    end

endmodule

// File: verilog/ice_cmd_top.sv
`timescale 1ns/1ps

// Command engine top level
// Receiver, executor, transmitter and the CMD6 capture
module ice_cmd_top #(
    parameter int unsigned turnaround_cycles = 6
) (
    input  logic                  sd_datInWrite_clk,
    input  logic                  sd_datInWrite_rst_,

    // Host link
    input  logic                  data_in,
    output logic                  data_out,
    output logic                  data_oe,

    output ice_cmd_pkg::led_t     led,

    // SD data-in stream
    input  logic                  dat_block_start,
    input  logic                  dat_trigger,
    input  ice_cmd_pkg::sd_word_t dat_data
);
    import ice_cmd_pkg::*;

    spi_msg_t   msg;
    logic       msg_valid;
    spi_resp_t  resp;
    logic       resp_load;
    logic [3:0] access_mode;

    // ============================================================
    // Message in
    // ============================================================
    spi_msg_rx spi_msg_rx_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .data_in            (data_in),
        .msg                (msg),
        .msg_valid          (msg_valid)
    );

    // ============================================================
    // Decode and execute
    // ============================================================
    cmd_exec cmd_exec_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .msg                (msg),
        .msg_valid          (msg_valid),
        .access_mode        (access_mode),
        .led                (led),
        .resp               (resp),
        .resp_load          (resp_load)
    );

    // ============================================================
    // Response out
    // ============================================================
    spi_resp_tx #(
        .turnaround_cycles  (turnaround_cycles)
    ) spi_resp_tx_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .resp               (resp),
        .resp_load          (resp_load),
        .data_out           (data_out),
        .data_oe            (data_oe)
    );

    // ============================================================
    // CMD6 access mode
    // ============================================================
    cmd6_mode_capture cmd6_mode_capture_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_block_start    (dat_block_start),
        .dat_trigger        (dat_trigger),
        .dat_data           (dat_data),
        .access_mode        (access_mode)
    );

endmodule

// File: tb/tb_ice_cmd_tasks.svh
`ifndef TB_ICE_CMD_TASKS_SVH
`define TB_ICE_CMD_TASKS_SVH

// ============================================================
// Host link and SD stream drivers
// ============================================================
function automatic logic [55:0] rand_arg();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[55:0];
endfunction

// Start bit then 64 bits MSB first, link left high for a following message
task automatic send_msg(input logic [7:0] msg_type, input logic [55:0] arg,
                        input logic back_to_back);
    spi_msg_t m;
    int       start_cyc;
    m.msg_type = msg_type;
    m.arg      = arg;
    @(posedge sd_datInWrite_clk);
    start_cyc = cyc;                    // DUT takes the start bit one edge later
    data_in <= 1'b1;
    if (msg_type[7]) begin
        rise_due      <= start_cyc + 68 + turnaround_cycles;
        resp_sent_cnt <= resp_sent_cnt + 1;
    end
    if (msg_type == msg_led_set) begin
        led_due <= start_cyc + 67;
        led_new <= arg[3:0];
    end
    for (int i = msg_len - 1; i >= 0; i--) begin
        @(posedge sd_datInWrite_clk);
        data_in <= m[i];
    end
    if (!back_to_back) begin
        @(posedge sd_datInWrite_clk);
        data_in <= 1'b0;
    end
endtask

// Samples data_out on falling edges while data_oe is high
task automatic collect_resp(input spi_resp_t expected);
    int        waited;
    spi_resp_t bits;
    logic      full_len;
    waited   = 0;
    bits     = '0;
    full_len = 1'b1;
    @(negedge sd_datInWrite_clk);
    while (!data_oe && waited < resp_wait_limit) begin
        @(negedge sd_datInWrite_clk);
        waited++;
    end
    if (!data_oe) begin
        $display("no response: data_oe stayed low for %0d cycles", resp_wait_limit);
        fail_run();
    end else begin
        for (int i = resp_len - 1; i >= 0; i--) begin
            bits[i] = data_out;
            if (!data_oe) begin
                full_len = 1'b0;
            end
            @(negedge sd_datInWrite_clk);
        end
        if (data_oe) begin
            full_len = 1'b0;            // Still driving after 64 bits
        end
        @(posedge sd_datInWrite_clk);
        exp_resp     <= expected;
        got_resp     <= bits;
        resp_len_ok  <= full_len;
        chk_resp     <= 1'b1;
        resp_got_cnt <= resp_got_cnt + 1;
        @(posedge sd_datInWrite_clk);
        chk_resp <= 1'b0;
    end
endtask

task automatic check_status();
    status_resp_t st;
    st             = '0;
    st.bad_cmd     = mdl_bad;
    st.led         = mdl_led;
    st.access_mode = mdl_mode;
    send_msg(msg_status, rand_arg(), 1'b0);
    collect_resp(spi_resp_t'(st));
endtask

// One 32-word block of random data, word 8 carries the access mode
task automatic stream_block();
    sd_word_t word;
    @(posedge sd_datInWrite_clk);
    dat_block_start <= 1'b1;
    for (int i = 0; i < cmd6_block_words; i++) begin
        word = sd_word_t'($urandom);
        @(posedge sd_datInWrite_clk);
        dat_block_start <= 1'b0;
        dat_trigger     <= 1'b1;
        dat_data        <= word;
        if (i == cmd6_mode_word_idx) begin
            mdl_mode = word[11:8];
        end
    end
    @(posedge sd_datInWrite_clk);
    dat_trigger <= 1'b0;
endtask

`endif

// File: tb/tb_ice_cmd.sv
`timescale 1ns/1ps

// Testbench for the command engine
module tb_ice_cmd;
    import ice_cmd_pkg::*;

    localparam int turnaround_cycles = 6;
    localparam int clk_half_ns       = 10;   // 20 ns period

    // Run length budget in clock cycles
    localparam int msg_cycles      = msg_len + 3;
    localparam int resp_cycles     = turnaround_cycles + resp_len + 8;
    localparam int num_msgs        = 10;
    localparam int resp_wait_limit = msg_cycles + resp_cycles;
    localparam int run_cycles      = num_msgs * (msg_cycles + resp_cycles)
                                     + 2 * cmd6_block_words + 200;

    logic     sd_datInWrite_clk = 1'b0;
    logic     sd_datInWrite_rst_;
    logic     data_in;
    logic     data_out;
    logic     data_oe;
    led_t     led;
    logic     dat_block_start;
    logic     dat_trigger;
    sd_word_t dat_data;

    // ============================================================
    // Reference model state and check strobes
    // ============================================================
    int         cyc           = 0;              // Rising edges seen
    int         rise_due      = 0;              // Edge where data_oe must rise
    int         led_due       = 32'h7fff_ffff;  // Edge where led takes led_new
    led_t       led_new       = '0;
    led_t       exp_led_q     = '0;
    logic       oe_prev       = 1'b0;
    int         resp_sent_cnt = 0;
    int         resp_got_cnt  = 0;
    logic       chk_resp      = 1'b0;
    logic       resp_len_ok   = 1'b1;
    spi_resp_t  exp_resp      = '0;
    spi_resp_t  got_resp      = '0;
    logic       mdl_bad       = 1'b0;
    led_t       mdl_led       = '0;
    logic [3:0] mdl_mode      = '0;

    ice_cmd_top #(
        .turnaround_cycles  (turnaround_cycles)
    ) ice_cmd_top_i (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .data_in            (data_in),
        .data_out           (data_out),
        .data_oe            (data_oe),
        .led                (led),
        .dat_block_start    (dat_block_start),
        .dat_trigger        (dat_trigger),
        .dat_data           (dat_data)
    );

    always #clk_half_ns sd_datInWrite_clk = ~sd_datInWrite_clk;

    task automatic fail_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge sd_datInWrite_clk) begin
        cyc     <= cyc + 1;
        oe_prev <= data_oe;
        if (cyc == led_due - 1) begin
            exp_led_q <= led_new;   // LEDSet lands at T66
        end
    end

    // ============================================================
    // Checks
    // ============================================================
    a_resp_value: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        chk_resp |-> got_resp == exp_resp)
        else begin
            $display("mismatch at %0t: data_out expected %h actual %h", $time, exp_resp, got_resp);
            fail_run();
        end

    a_resp_len: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        chk_resp |-> resp_len_ok)
        else begin
            $display("data_oe was not high for exactly %0d cycles at %0t", resp_len, $time);
            fail_run();
        end

    // A rising data_oe needs a message that asked for an answer
    a_oe_expected: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        (data_oe && !oe_prev) |-> resp_sent_cnt != resp_got_cnt)
        else begin
            $display("data_oe rose at %0t with no response pending", $time);
            fail_run();
        end

    a_oe_time: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        (data_oe && !oe_prev && resp_sent_cnt != resp_got_cnt) |-> cyc == rise_due)
        else begin
            $display("mismatch at %0t: data_oe rise cycle expected %0d actual %0d",
                     $time, rise_due, cyc);
            fail_run();
        end

    a_led: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        led == exp_led_q)
        else begin
            $display("mismatch at %0t: led expected %h actual %h", $time, exp_led_q, led);
            fail_run();
        end

`include "tb_ice_cmd_tasks.svh"

    initial begin
        repeat (run_cycles) @(posedge sd_datInWrite_clk);
        $display("watchdog expired after %0d cycles before the sequence ended", run_cycles);
        fail_run();
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        logic [55:0] arg;
        logic [55:0] led_arg;

        void'($urandom(10699));
        sd_datInWrite_rst_ = 1'b0;
        data_in            = 1'b0;
        dat_block_start    = 1'b0;
        dat_trigger        = 1'b0;
        dat_data           = '0;
        repeat (4) @(posedge sd_datInWrite_clk);
        sd_datInWrite_rst_ <= 1'b1;
        repeat (2) @(posedge sd_datInWrite_clk);

        check_status();                         // Reset values
        send_msg(msg_nop, rand_arg(), 1'b0);

        arg = rand_arg();
        send_msg(msg_echo, arg, 1'b0);
        collect_resp({8'h00, arg});

        // No answer for LEDSet so data_oe stays low
        arg = rand_arg();
        send_msg(msg_led_set, arg, 1'b0);
        mdl_led = arg[3:0];
        repeat (resp_cycles) @(posedge sd_datInWrite_clk);

        stream_block();
        check_status();

        send_msg(8'hA5, rand_arg(), 1'b0);      // Unknown type with bit 7 set
        mdl_bad = 1'b1;
        collect_resp('0);
        check_status();

        // Echo with an LEDSet right behind it
        arg     = rand_arg();
        led_arg = rand_arg();
        send_msg(msg_echo, arg, 1'b1);
        fork
            send_msg(msg_led_set, led_arg, 1'b0);
            collect_resp({8'h00, arg});
        join
        mdl_led = led_arg[3:0];
        repeat (8) @(posedge sd_datInWrite_clk);
        check_status();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+tb
verilog/ice_cmd_pkg.sv
verilog/spi_msg_rx.sv
verilog/cmd_exec.sv
verilog/spi_resp_tx.sv
verilog/cmd6_mode_capture.sv
verilog/ice_cmd_top.sv
tb/tb_ice_cmd.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ice_cmd -f tb.f &&
./obj_dir/Vtb_ice_cmd | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
